// File: include/pe_params.svh
`ifndef PE_PARAMS_SVH
`define PE_PARAMS_SVH

// ====================
// node identity
// ====================
// mesh address, x in bits 3:0 and y in bits 11:8
`define PE_NODE_ADDRESS 16'h0102

// ====================
// sizes
// ====================
`define PE_RAM_WORDS    1024
`define PE_RAM_AW       $clog2(`PE_RAM_WORDS)
`define PE_FIFO_DEPTH   8
// router local port input slots
`define PE_LINK_CREDITS 4

// ====================
// memory map
// ====================
`define PE_RAM_BASE     32'h4000_0000
`define PE_RAM_LAST     32'h5fff_ffff
`define PE_DMA_BASE     32'h2000_0000

`endif

// File: hw/pe_pkg.sv
`default_nettype none

package pe_pkg;

  // ====================
  // base types
  // ====================
  typedef logic [31:0] word_t;
  typedef logic [31:0] flit_t;
  typedef logic [31:0] addr_t;
  // bit 1 is send done
  typedef logic [7:0]  irq_t;

  // ====================
  // bundles
  // ====================
  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  we;
  } bus_req_t;

  typedef struct packed {
    logic  valid;
    flit_t data;
  } link_t;

  // send setup handed from decoder to engine
  typedef struct packed {
    logic [15:0] dest;
    addr_t       addr;
    logic [15:0] size;
  } dma_cfg_t;

  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    SIZE,
    READ,
    DONE
  } send_state_t;

endpackage

`default_nettype wire

// File: hw/pe_dual_port_ram.sv
`default_nettype none
`include "pe_params.svh"

module pe_dual_port_ram (
  input  wire                         clock_i,
  input  wire                         reset_i,
  // bus side, read and write
  input  wire  [`PE_RAM_AW-1:0]       a_addr_i,
  input  wire  pe_pkg::word_t         a_wdata_i,
  input  wire                         a_we_i,
  output pe_pkg::word_t               a_rdata_o,
  // dma side, read only
  input  wire  [`PE_RAM_AW-1:0]       b_addr_i,
  output pe_pkg::word_t               b_rdata_o
);

  pe_pkg::word_t mem [`PE_RAM_WORDS];

  // write port
  always_ff @(posedge clock_i) begin
    if (a_we_i) begin
      mem[a_addr_i] <= a_wdata_i;
    end
  end

  // registered reads, old data on a same-cycle write
  always_ff @(posedge clock_i) begin
    if (!reset_i) begin
      a_rdata_o <= '0;
      b_rdata_o <= '0;
    end else begin
      a_rdata_o <= mem[a_addr_i];
      b_rdata_o <= mem[b_addr_i];
    end
  end

endmodule

`default_nettype wire

// File: hw/pe_mmio_decoder.sv
`default_nettype none
`include "pe_params.svh"

module pe_mmio_decoder (
  input  wire                         clock_i,
  input  wire                         reset_i,
  input  wire  pe_pkg::bus_req_t      bus_i,
  output pe_pkg::word_t               bus_rdata_o,
  // ram port a
  output logic [`PE_RAM_AW-1:0]       ram_addr_o,
  output pe_pkg::word_t               ram_wdata_o,
  output logic                        ram_we_o,
  input  wire  pe_pkg::word_t         ram_rdata_i,
  // send engine
  output pe_pkg::dma_cfg_t            cfg_o,
  output logic                        start_o,
  input  wire                         busy_i,
  input  wire                         done_i,
  output pe_pkg::irq_t                irq_o
);

  localparam pe_pkg::addr_t DMA_NODE   = `PE_DMA_BASE + 32'h00;
  localparam pe_pkg::addr_t DMA_DEST   = `PE_DMA_BASE + 32'h04;
  localparam pe_pkg::addr_t DMA_ADDR   = `PE_DMA_BASE + 32'h08;
  localparam pe_pkg::addr_t DMA_SIZE   = `PE_DMA_BASE + 32'h0c;
  localparam pe_pkg::addr_t DMA_CMD    = `PE_DMA_BASE + 32'h10;
  localparam pe_pkg::addr_t DMA_STATUS = `PE_DMA_BASE + 32'h14;

  // the dma block sees words in the opposite byte order
  function automatic pe_pkg::word_t byte_swap(input pe_pkg::word_t data);
    return {data[7:0], data[15:8], data[23:16], data[31:24]};
  endfunction

  function automatic logic in_ram(input pe_pkg::addr_t addr);
    return (addr >= `PE_RAM_BASE) && (addr <= `PE_RAM_LAST);
  endfunction

  pe_pkg::addr_t wr_addr;
  pe_pkg::addr_t ram_offset;
  pe_pkg::word_t wr_value;
  pe_pkg::addr_t dly_addr_q;

  pe_pkg::word_t dest_q;
  pe_pkg::word_t send_addr_q;
  pe_pkg::word_t size_q;
  pe_pkg::word_t cmd_q;

  // ====================
  // write side
  // ====================
  assign wr_addr    = {bus_i.addr[31:2], 2'b00};
  assign wr_value   = byte_swap(bus_i.wdata);
  assign ram_offset = bus_i.addr - `PE_RAM_BASE;

  // word index wraps inside the ram depth
  assign ram_addr_o  = ram_offset[`PE_RAM_AW+1:2];
  assign ram_wdata_o = bus_i.wdata;
  assign ram_we_o    = bus_i.we && in_ram(bus_i.addr);

  always_ff @(posedge clock_i) begin
    if (!reset_i) begin
      dest_q      <= '0;
      send_addr_q <= '0;
      size_q      <= '0;
      cmd_q       <= '0;
      start_o     <= 1'b0;
    end else begin
      start_o <= 1'b0;
      if (bus_i.we) begin
        case (wr_addr)
          DMA_DEST: dest_q      <= wr_value;
          DMA_ADDR: send_addr_q <= wr_value;
          DMA_SIZE: size_q      <= wr_value;
          DMA_CMD: begin
            cmd_q <= wr_value;
            // ignored while a send runs or one is about to start
            start_o <= wr_value[0] && !busy_i && !start_o;
          end
          default: ;
        endcase
      end
    end
  end

  assign cfg_o.dest = dest_q[15:0];
  assign cfg_o.addr = send_addr_q;
  assign cfg_o.size = size_q[15:0];

  // ====================
  // read side
  // ====================
  // data comes back one cycle after the address
  always_ff @(posedge clock_i) begin
    if (!reset_i) begin
      dly_addr_q <= '0;
    end else begin
      dly_addr_q <= {bus_i.addr[31:2], 2'b00};
    end
  end

  always_comb begin
    if (in_ram(dly_addr_q)) begin
      bus_rdata_o = ram_rdata_i;
    end else begin
      case (dly_addr_q)
        DMA_NODE:   bus_rdata_o = byte_swap({16'h0000, `PE_NODE_ADDRESS});
        DMA_DEST:   bus_rdata_o = byte_swap(dest_q);
        DMA_ADDR:   bus_rdata_o = byte_swap(send_addr_q);
        DMA_SIZE:   bus_rdata_o = byte_swap(size_q);
        DMA_CMD:    bus_rdata_o = byte_swap(cmd_q);
        DMA_STATUS: bus_rdata_o = byte_swap({31'h0, busy_i});
        // unmapped space
        default:    bus_rdata_o = '0;
      endcase
    end
  end

  // ====================
  // interrupts
  // ====================
  always_ff @(posedge clock_i) begin
    if (!reset_i) begin
      irq_o <= '0;
    end else begin
      irq_o <= {6'b000000, done_i, 1'b0};
    end
  end

endmodule

`default_nettype wire

// File: hw/dma_send_engine.sv
`default_nettype none
`include "pe_params.svh"

module dma_send_engine (
  input  wire                         clock_i,
  input  wire                         reset_i,
  input  wire  pe_pkg::dma_cfg_t      cfg_i,
  input  wire                         start_i,
  output logic                        busy_o,
  output logic                        done_o,
  // ram port b
  output logic [`PE_RAM_AW-1:0]       ram_addr_o,
  input  wire  pe_pkg::word_t         ram_rdata_i,
  // flit fifo
  output logic                        push_o,
  output pe_pkg::flit_t               flit_o,
  input  wire                         full_i
);

  pe_pkg::send_state_t  state_q;
  pe_pkg::send_state_t  state_d;
  logic [15:0]          dest_q;
  logic [15:0]          count_q;
  logic [15:0]          count_d;
  logic [`PE_RAM_AW-1:0] idx_q;
  logic [`PE_RAM_AW-1:0] idx_d;
  pe_pkg::addr_t        start_offset;

  assign start_offset = cfg_i.addr - `PE_RAM_BASE;

  always_comb begin
    state_d = state_q;
    count_d = count_q;
    idx_d   = idx_q;
    push_o  = 1'b0;
    flit_o  = ram_rdata_i;
    case (state_q)
      pe_pkg::IDLE: begin
        if (start_i) begin
          state_d = pe_pkg::HEADER;
          count_d = cfg_i.size;
          idx_d   = start_offset[`PE_RAM_AW+1:2];
        end
      end
      pe_pkg::HEADER: begin
        flit_o = {`PE_NODE_ADDRESS, dest_q};
        push_o = !full_i;
        if (!full_i) begin
          state_d = pe_pkg::SIZE;
        end
      end
      pe_pkg::SIZE: begin
        flit_o = {16'h0000, count_q};
        push_o = !full_i;
        if (!full_i) begin
          state_d = (count_q == 16'd0) ? pe_pkg::DONE : pe_pkg::READ;
        end
      end
      pe_pkg::READ: begin
        // ram output always holds the word at idx_q
        push_o = !full_i;
        if (!full_i) begin
          idx_d   = idx_q + 1'b1;
          count_d = count_q - 1'b1;
          if (count_q == 16'd1) begin
            state_d = pe_pkg::DONE;
          end
        end
      end
      pe_pkg::DONE: state_d = pe_pkg::IDLE;
      default:      state_d = pe_pkg::IDLE;
    endcase
  end

  // fetch the next word early so it is ready on the following cycle
  assign ram_addr_o = idx_d;

  always_ff @(posedge clock_i) begin
    if (!reset_i) begin
      state_q <= pe_pkg::IDLE;
      dest_q  <= '0;
      count_q <= '0;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
      idx_q   <= idx_d;
      if (state_q == pe_pkg::IDLE && start_i) begin
        dest_q <= cfg_i.dest;
      end
    end
  end

  assign busy_o = (state_q != pe_pkg::IDLE);
  assign done_o = (state_q == pe_pkg::DONE);

endmodule

`default_nettype wire

// File: hw/flit_fifo.sv
`default_nettype none
`include "pe_params.svh"

module flit_fifo #(
  parameter int unsigned DEPTH = `PE_FIFO_DEPTH
) (
  input  wire                         clock_i,
  input  wire                         reset_i,
  input  wire                         push_i,
  input  wire  pe_pkg::flit_t         flit_i,
  input  wire                         pop_i,
  output pe_pkg::flit_t               flit_o,
  output logic                        full_o,
  output logic                        empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  pe_pkg::flit_t    mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // pointer advance with wrap for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clock_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= flit_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (!reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // head of queue visible without a pop
  assign flit_o  = mem[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

// File: hw/link_tx.sv
`default_nettype none
`include "pe_params.svh"

module link_tx #(
  parameter int unsigned CREDITS = `PE_LINK_CREDITS
) (
  input  wire                         clock_i,
  input  wire                         reset_i,
  input  wire                         empty_i,
  input  wire  pe_pkg::flit_t         flit_i,
  output logic                        pop_o,
  input  wire                         credit_i,
  output pe_pkg::link_t               link_o
);

  localparam int unsigned CNT_W = $clog2(CREDITS + 1);

  // free slots in the router input buffer
  logic [CNT_W-1:0] credit_q;

  assign pop_o = !empty_i && (credit_q != '0);

  always_ff @(posedge clock_i) begin
    if (!reset_i) begin
      credit_q <= CNT_W'(CREDITS);
    end else begin
      case ({pop_o, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;
      endcase
    end
  end

  // one valid cycle per popped flit
  always_ff @(posedge clock_i) begin
    if (!reset_i) begin
      link_o.valid <= 1'b0;
    end else begin
      link_o.valid <= pop_o;
    end
  end

  always_ff @(posedge clock_i) begin
    if (pop_o) begin
      link_o.data <= flit_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/pe_node.sv
`default_nettype none
`include "pe_params.svh"

module pe_node (
  input  wire                         clock,
  input  wire                         reset,
  input  wire  pe_pkg::bus_req_t      bus_i,
  output pe_pkg::word_t               bus_rdata_o,
  output pe_pkg::link_t               link_o,
  input  wire                         credit_i,
  output pe_pkg::irq_t                irq_o
);

  // ====================
  // internal nets
  // ====================
  logic [`PE_RAM_AW-1:0] ram_a_addr;
  pe_pkg::word_t         ram_a_wdata;
  logic                  ram_a_we;
  pe_pkg::word_t         ram_a_rdata;
  logic [`PE_RAM_AW-1:0] ram_b_addr;
  pe_pkg::word_t         ram_b_rdata;

  pe_pkg::dma_cfg_t      cfg;
  logic                  start;
  logic                  busy;
  logic                  done;

  logic                  push;
  pe_pkg::flit_t         push_flit;
  logic                  full;
  logic                  pop;
  pe_pkg::flit_t         head_flit;
  logic                  empty;

  // ====================
  // blocks
  // ====================
  pe_mmio_decoder u_decoder (
    .clock_i     (clock),
    .reset_i     (reset),
    .bus_i       (bus_i),
    .bus_rdata_o (bus_rdata_o),
    .ram_addr_o  (ram_a_addr),
    .ram_wdata_o (ram_a_wdata),
    .ram_we_o    (ram_a_we),
    .ram_rdata_i (ram_a_rdata),
    .cfg_o       (cfg),
    .start_o     (start),
    .busy_i      (busy),
    .done_i      (done),
    .irq_o       (irq_o)
  );

  pe_dual_port_ram u_ram (
    .clock_i   (clock),
    .reset_i   (reset),
    .a_addr_i  (ram_a_addr),
    .a_wdata_i (ram_a_wdata),
    .a_we_i    (ram_a_we),
    .a_rdata_o (ram_a_rdata),
    .b_addr_i  (ram_b_addr),
    .b_rdata_o (ram_b_rdata)
  );

  dma_send_engine u_engine (
    .clock_i     (clock),
    .reset_i     (reset),
    .cfg_i       (cfg),
    .start_i     (start),
    .busy_o      (busy),
    .done_o      (done),
    .ram_addr_o  (ram_b_addr),
    .ram_rdata_i (ram_b_rdata),
    .push_o      (push),
    .flit_o      (push_flit),
    .full_i      (full)
  );

  flit_fifo #(
    .DEPTH (`PE_FIFO_DEPTH)
  ) u_fifo (
    .clock_i (clock),
    .reset_i (reset),
    .push_i  (push),
    .flit_i  (push_flit),
    .pop_i   (pop),
    .flit_o  (head_flit),
    .full_o  (full),
    .empty_o (empty)
  );

  link_tx #(
    .CREDITS (`PE_LINK_CREDITS)
  ) u_link_tx (
    .clock_i  (clock),
    .reset_i  (reset),
    .empty_i  (empty),
    .flit_i   (head_flit),
    .pop_o    (pop),
    .credit_i (credit_i),
    .link_o   (link_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic clock_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clock_o = 1'b0;
    forever #(PERIOD_NS / 2) clock_o = ~clock_o;
  end

  // active low, released on a rising edge
  initial begin
    reset_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_o);
    reset_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/pe_node_chk.sv
`default_nettype none
`include "pe_params.svh"

module pe_node_chk (
  input  wire                  clock_i,
  input  wire                  reset_i,
  input  wire  pe_pkg::link_t  link_i,
  input  wire                  credit_i,
  input  wire                  push_i,
  input  wire                  full_i,
  input  wire  pe_pkg::irq_t   irq_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // flits on the link not yet answered by a credit
  logic [3:0] in_flight_q;

  always_ff @(posedge clock_i) begin
    if (!reset_i) begin
      in_flight_q <= '0;
    end else begin
      case ({link_i.valid, credit_i})
        2'b10:   in_flight_q <= in_flight_q + 4'd1;
        2'b01:   in_flight_q <= in_flight_q - 4'd1;
        default: ;
      endcase
    end
  end

  // ====================
  // properties
  // ====================
  credit_respected: assert property (@(posedge clock_i) disable iff (!reset_i)
    link_i.valid |-> (in_flight_q < 4'(`PE_LINK_CREDITS)))
    else $error("link flit sent while the router had no free slot");

  no_push_when_full: assert property (@(posedge clock_i) disable iff (!reset_i)
    push_i |-> !full_i)
    else $error("flit pushed into a full FIFO");

  irq_single_cycle: assert property (@(posedge clock_i) disable iff (!reset_i)
    irq_i[1] |=> !irq_i[1])
    else $error("send done interrupt held longer than one cycle");

endmodule

`default_nettype wire

// File: sim/pe_node_tb.sv
`default_nettype none
`include "pe_params.svh"

module pe_node_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned   WAIT_LIMIT = 2000;
  localparam pe_pkg::addr_t DMA_BASE   = `PE_DMA_BASE;

  logic             clock;
  logic             reset;
  pe_pkg::bus_req_t bus_req = '0;
  pe_pkg::word_t    bus_rdata;
  pe_pkg::link_t    link;
  logic             credit = 1'b0;
  pe_pkg::irq_t     irq;

  integer        seed = 86346;
  pe_pkg::word_t ram_image [`PE_RAM_WORDS];
  logic [15:0]   exp_dest = '0;
  pe_pkg::addr_t exp_addr = '0;
  logic [15:0]   exp_size = '0;
  int unsigned   rx_count = 0;
  int unsigned   rx_base = 0;
  int unsigned   irq_count = 0;
  int unsigned   owed = 0;
  int unsigned   gap = 0;
  logic          hold_credits = 1'b0;
  int unsigned   errors = 0;
  int unsigned   tests_run = 0;
  int unsigned   tests_bad = 0;
  bit            aborted = 1'b0;

  tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(3)) u_clock_gen (
    .clock_o (clock),
    .reset_o (reset)
  );

  pe_node dut (
    .clock       (clock),
    .reset       (reset),
    .bus_i       (bus_req),
    .bus_rdata_o (bus_rdata),
    .link_o      (link),
    .credit_i    (credit),
    .irq_o       (irq)
  );

  bind pe_node pe_node_chk u_chk (
    .clock_i  (clock),
    .reset_i  (reset),
    .link_i   (link_o),
    .credit_i (credit_i),
    .push_i   (push),
    .full_i   (full),
    .irq_i    (irq_o)
  );

  // ====================
  // reference model
  // ====================
  function automatic pe_pkg::word_t reverse_bytes(input pe_pkg::word_t value);
    pe_pkg::word_t result;
    for (int i = 0; i < 4; i++) begin
      result[8*i +: 8] = value[8*(3-i) +: 8];
    end
    return result;
  endfunction

  // flit n of the packet for the current send setup
  function automatic pe_pkg::flit_t expected_flit(input int unsigned n);
    int unsigned first;
    if (n == 0) begin
      return {`PE_NODE_ADDRESS, exp_dest};
    end
    if (n == 1) begin
      return {16'h0000, exp_size};
    end
    first = (exp_addr - `PE_RAM_BASE) / 4;
    return ram_image[(first + n - 2) % `PE_RAM_WORDS];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
    aborted = 1'b1;
  endtask

  task automatic finish_test(input string name, input int unsigned errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %-26s ok", name);
    end else begin
      tests_bad++;
      $display("test %-26s fail", name);
    end
  endtask

  // ====================
  // bus access
  // ====================
  task automatic write_word(input pe_pkg::addr_t address, input pe_pkg::word_t data);
    @(posedge clock);
    bus_req <= '{addr: address, wdata: data, we: 1'b1};
    @(posedge clock);
    bus_req <= '{addr: address, wdata: '0, we: 1'b0};
  endtask

  // data is valid one cycle after the address
  task automatic check_read(input string name, input pe_pkg::addr_t address,
                            input pe_pkg::word_t want);
    @(posedge clock);
    bus_req <= '{addr: address, wdata: '0, we: 1'b0};
    @(posedge clock);
    @(negedge clock);
    check_value(name, bus_rdata, want);
  endtask

  // ====================
  // link side
  // ====================
  always @(posedge clock) begin
    if (reset && link.valid) begin
      if (rx_count - rx_base < 32'(exp_size) + 2) begin
        check_value("link_o.data", link.data, expected_flit(rx_count - rx_base));
      end else begin
        $display("unexpected flit on the link after the end of the packet");
        errors++;
      end
      rx_count++;
    end
    if (reset && irq[1]) begin
      irq_count++;
    end
    // only the send done bit may ever be set
    if (reset) begin
      check_value("irq_o", 32'(irq & 8'hfd), '0);
    end
  end

  // router frees one slot a few cycles after each flit
  always @(posedge clock) begin
    if (!reset) begin
      owed = 0;
      gap = 0;
      credit <= 1'b0;
    end else begin
      credit <= 1'b0;
      if (link.valid) begin
        owed++;
      end
      if (gap != 0) begin
        gap--;
      end else if (owed != 0 && !hold_credits) begin
        credit <= 1'b1;
        owed--;
        gap = 1 + ($unsigned($random(seed)) % 4);
      end
    end
  end

  task automatic send_block(input string name, input logic [15:0] dest,
                            input int unsigned index, input logic [15:0] size,
                            input bit throttle);
    int unsigned errs;
    int unsigned irq_before;
    int unsigned n;
    errs = errors;
    @(negedge clock);
    exp_dest   = dest;
    exp_addr   = `PE_RAM_BASE + 4 * index;
    exp_size   = size;
    rx_base    = rx_count;
    irq_before = irq_count;
    write_word(DMA_BASE + 32'h04, reverse_bytes({16'h0000, dest}));
    write_word(DMA_BASE + 32'h08, reverse_bytes(exp_addr));
    write_word(DMA_BASE + 32'h0c, reverse_bytes({16'h0000, size}));
    if (throttle) begin
      @(posedge clock);
      hold_credits <= 1'b1;
    end
    write_word(DMA_BASE + 32'h10, reverse_bytes(32'h0000_0001));
    check_read("bus_rdata_o status", DMA_BASE + 32'h14, reverse_bytes(32'h0000_0001));
    if (throttle) begin
      n = 0;
      while (!dut.u_fifo.full_o && n < WAIT_LIMIT) begin
        @(negedge clock);
        n++;
      end
      if (!dut.u_fifo.full_o) report_timeout("the flit FIFO to fill");
      check_value("link_o.valid count", rx_count - rx_base, `PE_LINK_CREDITS);
      @(posedge clock);
      hold_credits <= 1'b0;
      @(negedge clock);
    end
    n = 0;
    while (irq_count == irq_before && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (irq_count == irq_before) report_timeout("the send done interrupt");
    n = 0;
    while (rx_count - rx_base < 32'(size) + 2 && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (rx_count - rx_base < 32'(size) + 2) report_timeout("the rest of the packet");
    n = 0;
    while (owed != 0 && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (owed != 0) report_timeout("the credits to come back");
    check_value("irq_o[1] pulse count", irq_count - irq_before, 1);
    check_read("bus_rdata_o status", DMA_BASE + 32'h14, '0);
    finish_test(name, errs);
  endtask

  // ====================
  // test sequence
  // ====================
  initial begin
    pe_pkg::word_t value;
    int unsigned   idx;
    int unsigned   n;
    int unsigned   errs;

    n = 0;
    while (reset !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (reset !== 1'b1) report_timeout("reset release");

    errs = errors;
    @(negedge clock);
    check_value("bus_rdata_o", bus_rdata, '0);
    check_value("link_o.valid", 32'(link.valid), '0);
    check_value("irq_o", 32'(irq), '0);
    finish_test("reset values", errs);

    errs = errors;
    for (int i = 0; i < 12; i++) begin
      idx   = $unsigned($random(seed)) % `PE_RAM_WORDS;
      value = $random(seed);
      ram_image[idx] = value;
      write_word(`PE_RAM_BASE + 4 * idx, value);
      check_read("bus_rdata_o ram", `PE_RAM_BASE + 4 * idx, value);
    end
    // the ram repeats through the whole region
    check_read("bus_rdata_o ram alias", `PE_RAM_BASE + 4 * (idx + `PE_RAM_WORDS), value);
    finish_test("ram write and read", errs);

    errs = errors;
    check_read("bus_rdata_o node", DMA_BASE, reverse_bytes({16'h0000, `PE_NODE_ADDRESS}));
    write_word(DMA_BASE + 32'h04, 32'h1234_5678);
    check_read("bus_rdata_o dest", DMA_BASE + 32'h04, 32'h1234_5678);
    write_word(DMA_BASE + 32'h08, 32'h89ab_cdef);
    check_read("bus_rdata_o addr", DMA_BASE + 32'h08, 32'h89ab_cdef);
    write_word(DMA_BASE + 32'h0c, 32'h0f1e_2d3c);
    check_read("bus_rdata_o size", DMA_BASE + 32'h0c, 32'h0f1e_2d3c);
    // start bit clear after reversal, so no send begins
    write_word(DMA_BASE + 32'h10, 32'h5a69_7886);
    check_read("bus_rdata_o cmd", DMA_BASE + 32'h10, 32'h5a69_7886);
    check_read("bus_rdata_o status", DMA_BASE + 32'h14, '0);
    check_read("bus_rdata_o dma gap", DMA_BASE + 32'h18, '0);
    check_read("bus_rdata_o unmapped", 32'h1000_0000, '0);
    finish_test("dma registers", errs);

    // payload area for the sends
    for (int i = 64; i < 96; i++) begin
      value = $random(seed);
      ram_image[i] = value;
      write_word(`PE_RAM_BASE + 4 * i, value);
    end
    if (!aborted) send_block("send of zero words", 16'h0304, 64, 16'd0, 1'b0);
    if (!aborted) send_block("send of three words", 16'h0001, 70, 16'd3, 1'b0);
    if (!aborted) send_block("send of eleven words", 16'h0a05, 72, 16'd11, 1'b0);
    if (!aborted) send_block("send with credits held", 16'h0203, 80, 16'd12, 1'b1);

    $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
hw/pe_pkg.sv
hw/pe_dual_port_ram.sv
hw/pe_mmio_decoder.sv
hw/dma_send_engine.sv
hw/flit_fifo.sv
hw/link_tx.sv
hw/pe_node.sv
sim/tb_clock_gen.sv
sim/pe_node_chk.sv
sim/pe_node_tb.sv

// File: Makefile
TOP = pe_node_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
